// ==== all.f ====
src/cpuPkg.sv
src/alu.sv
src/regFile.sv
src/instrDecoder.sv
src/cpu.sv
testbench/clockGen.sv
testbench/cpu_assertions.sv
testbench/cpuTb.sv

// ==== testbench/cpu_stimulus.txt ====
# P addr w0 w1 w2 w3 : four program words from addr    D addr byte : initial data byte
# S test addr data : expected store, in program order
P 0000 2806 1006 33C6 3108
P 0004 1016 4A76 4108 55A6
P 0008 63C6 5600 1026 5108
P 000C 5602 1036 5108 5603
P 0010 1046 5108 5604 1056
P 0014 5108 5405 1066 5108
P 0018 7C86 8506 7800 7801
P 001C 1076 7108 9426 A426
P 0020 9A02 000A 0025 1086
P 0024 9108 B016 BB00 000B
P 0028 0030 1096 B108 C006
P 002C D906 EC07 10A6 E108
P 0030 0009 0034 10B6 E108
P 0034 10C6 3108 000C 4108
D 9000 E3
S 1 8000 3C
S 1 8001 A7
S 2 8002 96
S 2 8003 5A
S 2 8004 18
S 2 8005 3C
S 2 8006 9B
S 3 8007 69
S 3 8009 02
S 4 800A E3
S 5 800C 3C

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    logic                   clk;
    logic                   reset;
    logic [ADDR_WIDTH-1:0]  iMemAddress;
    logic [INSTR_WIDTH-1:0] iMemOut;
    logic                   iMemReadEnable;
    logic [ADDR_WIDTH-1:0]  dMemAddress;
    logic [DATA_WIDTH-1:0]  dMemIn;
    logic [DATA_WIDTH-1:0]  dMemOut;
    logic                   dMemWriteEn;
    logic                   dMemReadEn;
    logic                   halted;

    logic [INSTR_WIDTH-1:0] iMem [0:65535];
    logic [DATA_WIDTH-1:0]  dMem [0:65535];

    // Expected stores in program order
    int                     expTest [$];
    logic [ADDR_WIDTH-1:0]  expAddr [$];
    logic [DATA_WIDTH-1:0]  expData [$];

    int testStores  [16];
    int testErrors  [16];
    bit testPrinted [16];
    int numTests;
    int storeIdx;
    int checkCount;
    int errorCount;
    bit loadOk;
    bit haltSeen;

    clockGen clockGen0 (
        .clk   (clk),
        .reset (reset)
    );

    cpu dut0 (
        .clk            (clk),
        .reset          (reset),
        .iMemAddress    (iMemAddress),
        .iMemOut        (iMemOut),
        .iMemReadEnable (iMemReadEnable),
        .dMemAddress    (dMemAddress),
        .dMemIn         (dMemIn),
        .dMemOut        (dMemOut),
        .dMemWriteEn    (dMemWriteEn),
        .dMemReadEn     (dMemReadEn),
        .halted         (halted)
    );

    // ******************************************************************
    // Memory models
    // ******************************************************************
    assign iMemOut = iMem[iMemAddress];     // Combinational reads
    // Read data only under the read strobe
    assign dMemOut = (dMemReadEn === 1'b1) ? dMem[dMemAddress] : 'x;

    always @(posedge clk) begin
        if (dMemWriteEn === 1'b1) begin
            dMem[dMemAddress] <= dMemIn;
        end
    end

    task automatic fillMemories();
        logic [ADDR_WIDTH-1:0] addr;
        for (int i = 0; i < 65536; i++) begin
            addr    = i[ADDR_WIDTH-1:0];
            iMem[i] = {addr[15:4] ^ addr[11:0], 4'hD};    // No-op code tagged by address
            dMem[i] = addr[15:8] ^ addr[7:0] ^ 8'hA5;
        end
    endtask

    task automatic loadStimulus(output bit ok);
        int                     fd;
        int                     n;
        int                     test;
        bit                     done;
        logic [7:0]             kind;
        logic [8*128-1:0]       comment;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [15:0]            value;
        logic [INSTR_WIDTH-1:0] words [4];
        fd   = $fopen("testbench/cpu_stimulus.txt", "r");
        ok   = (fd != 0);
        done = !ok;
        while (!done) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1) begin
                done = 1'b1;
            end else begin
                case (kind)
                    "#": n = $fgets(comment, fd);
                    "P": begin
                        n = $fscanf(fd, "%h %h %h %h %h", addr, words[0], words[1],
                                    words[2], words[3]);
                        ok = ok && (n == 5);
                        for (int k = 0; k < 4; k++) begin
                            iMem[addr + k] = words[k];
                        end
                    end
                    "D": begin
                        n  = $fscanf(fd, "%h %h", addr, value);
                        ok = ok && (n == 2);
                        dMem[addr] = value[DATA_WIDTH-1:0];
                    end
                    "S": begin
                        n  = $fscanf(fd, "%d %h %h", test, addr, value);
                        ok = ok && (n == 3) && (test > 0) && (test < 16);
                        expTest.push_back(test);
                        expAddr.push_back(addr);
                        expData.push_back(value[DATA_WIDTH-1:0]);
                        if (test > numTests) numTests = test;
                    end
                    default: begin
                        ok   = 1'b0;    // Unknown record kind
                        done = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        ok = ok && (expAddr.size() > 0);
    endtask

    // ******************************************************************
    // Checking
    // ******************************************************************
    function automatic int currentTest();
        int t;
        if (storeIdx < expTest.size()) begin
            t = expTest[storeIdx];
        end else begin
            t = numTests;
        end
        return t;
    endfunction

    task automatic reportTest(input int t);
        $display("test %0d finished: %0d stores checked, %0d errors", t, testStores[t],
                 testErrors[t]);
        testPrinted[t] = 1'b1;
    endtask

    task automatic checkStore();
        int t;
        if (storeIdx >= expAddr.size()) begin
            $display("Unexpected store at %0t: %h written to %h past the expected list",
                     $time, dMemIn, dMemAddress);
            errorCount++;
            testErrors[numTests]++;
        end else begin
            t = expTest[storeIdx];
            checkCount++;
            if (dMemAddress !== expAddr[storeIdx]) begin
                $display("MISMATCH at %0t: dMemAddress expected %h, actual %h", $time,
                         expAddr[storeIdx], dMemAddress);
                errorCount++;
                testErrors[t]++;
            end
            if (dMemIn !== expData[storeIdx]) begin
                $display("MISMATCH at %0t: dMemIn expected %h, actual %h", $time,
                         expData[storeIdx], dMemIn);
                errorCount++;
                testErrors[t]++;
            end
            testStores[t]++;
            storeIdx++;
            // Final test closes after the halt checks
            if (storeIdx < expAddr.size() && expTest[storeIdx] != t) reportTest(t);
        end
    endtask

    task automatic watchUntilHalt(output bit seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 2000) begin
            @(negedge clk);                 // Mid-cycle where outputs have settled
            cycles++;
            if (dMemWriteEn === 1'b1) checkStore();
            seen = (halted === 1'b1);
            // Every running cycle fetches a word
            if (!seen && iMemReadEnable !== 1'b1) begin
                $display("MISMATCH at %0t: iMemReadEnable expected 1, actual %b", $time,
                         iMemReadEnable);
                errorCount++;
                testErrors[currentTest()]++;
            end
        end
    endtask

    task automatic checkAfterHalt();
        repeat (20) begin
            @(negedge clk);
            if (dMemWriteEn !== 1'b0) begin
                $display("MISMATCH at %0t: dMemWriteEn expected 0, actual %b", $time,
                         dMemWriteEn);
                errorCount++;
                testErrors[numTests]++;
            end
            if (halted !== 1'b1) begin
                $display("MISMATCH at %0t: halted expected 1, actual %b", $time, halted);
                errorCount++;
                testErrors[numTests]++;
            end
        end
        if (storeIdx != expAddr.size()) begin
            $display("Store count wrong: expected %0d, saw %0d", expAddr.size(), storeIdx);
            errorCount++;
            testErrors[numTests]++;
        end
    endtask

    // ******************************************************************
    // Run
    // ******************************************************************
    initial begin
        numTests   = 0;
        storeIdx   = 0;
        checkCount = 0;
        errorCount = 0;
        haltSeen   = 1'b0;
        fillMemories();
        loadStimulus(loadOk);
        if (!loadOk) begin
            $display("Stimulus file missing or malformed, program not run");
            errorCount++;
        end else begin
            watchUntilHalt(haltSeen);
            if (haltSeen) begin
                checkAfterHalt();
            end else begin
                $display("Timeout: halted not raised within 2000 cycles");
                errorCount++;
                testErrors[numTests]++;
            end
        end
        for (int t = 1; t <= numTests; t++) begin
            if (!testPrinted[t]) reportTest(t);
        end
        $display("Summary: %0d tests, %0d store checks, %0d errors", numTests, checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/cpu_assertions.sv ====
`timescale 1ns/1ps

module cpu_assertions (
    input logic                          clk,
    input logic                          reset,
    input logic                          dMemWriteEn,
    input logic                          dMemReadEn,
    input logic                          halted,
    input logic [cpuPkg::ADDR_WIDTH-1:0] iMemAddress
);

    // ******************************************************************
    // Data memory strobes
    // ******************************************************************
    strobesExclusive: assert property (@(posedge clk) !(dMemWriteEn && dMemReadEn))
        else $error("dMemWriteEn and dMemReadEn high in the same cycle");

    quietInReset: assert property (@(posedge clk) reset |-> (!dMemWriteEn && !dMemReadEn))
        else $error("Data memory strobe while reset is high");

    // Fetch address frozen once the core has stopped
    pcHeldWhenHalted: assert property (
        @(posedge clk) disable iff (reset) halted |=> $stable(iMemAddress))
        else $error("iMemAddress moved while halted");

endmodule

bind cpu cpu_assertions cpuAssertions0 (
    .clk         (clk),
    .reset       (reset),
    .dMemWriteEn (dMemWriteEn),
    .dMemReadEn  (dMemReadEn),
    .halted      (halted),
    .iMemAddress (iMemAddress)
);

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    // 4 ns period, reset held for 16 rising edges
    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;               // Released on a falling edge
    end

    always #2 clk = ~clk;

endmodule

// ==== src/cpu.sv ====
`timescale 1ns/1ps

module cpu (
    input  logic                           clk,
    input  logic                           reset,
    output logic [cpuPkg::ADDR_WIDTH-1:0]  iMemAddress,
    input  logic [cpuPkg::INSTR_WIDTH-1:0] iMemOut,
    output logic                           iMemReadEnable,
    output logic [cpuPkg::ADDR_WIDTH-1:0]  dMemAddress,
    output logic [cpuPkg::DATA_WIDTH-1:0]  dMemIn,
    input  logic [cpuPkg::DATA_WIDTH-1:0]  dMemOut,
    output logic                           dMemWriteEn,
    output logic                           dMemReadEn,
    output logic                           halted
);
    import cpuPkg::*;

    // Decoder controls
    logic    regWriteEn;
    regSrcT  regSrc;
    aluBSelT aluBSel;
    aluModeT aluMode;
    logic    flagEnable;
    pcSelT   pcSel;
    logic    pcWriteEn;

    // Datapath
    logic [DATA_WIDTH-1:0] immByte;
    logic [DATA_WIDTH-1:0] regWriteData;
    logic [DATA_WIDTH-1:0] regOutA;
    logic [DATA_WIDTH-1:0] regOutB;
    logic [DATA_WIDTH-1:0] regOutC;
    logic [DATA_WIDTH-1:0] aluDataB;
    logic [DATA_WIDTH-1:0] aluResult;
    logic                  aluCarry;
    logic                  aluZero;
    logic                  aluNeg;

    // Status and PC
    logic                  carryFlag;
    logic                  zeroFlag;
    logic                  negativeFlag;
    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] nextPc;

    assign immByte = iMemOut[11:4];

    // ******************************************************************
    // Decoder
    // ******************************************************************
    instrDecoder decoder0 (
        .clk            (clk),
        .reset          (reset),
        .instr          (iMemOut),
        .carryFlag      (carryFlag),
        .zeroFlag       (zeroFlag),
        .regWriteEn     (regWriteEn),
        .regSrc         (regSrc),
        .aluBSel        (aluBSel),
        .aluMode        (aluMode),
        .flagEnable     (flagEnable),
        .pcSel          (pcSel),
        .pcWriteEn      (pcWriteEn),
        .dMemReadEn     (dMemReadEn),
        .dMemWriteEn    (dMemWriteEn),
        .iMemReadEnable (iMemReadEnable),
        .halted         (halted)
    );

    // ******************************************************************
    // Register file and its write source
    // ******************************************************************
    always_comb begin
        case (regSrc)
            REG_SRC_IMM:  regWriteData = immByte;
            REG_SRC_DMEM: regWriteData = dMemOut;
            default:      regWriteData = aluResult;
        endcase
    end

    regFile regFile0 (
        .clk       (clk),
        .reset     (reset),
        .selA      (iMemOut[15:12]),    // rd
        .selB      (iMemOut[11:8]),     // rs
        .writeData (regWriteData),
        .writeEn   (regWriteEn),
        .outA      (regOutA),
        .outB      (regOutB),
        .outC      (regOutC)
    );

    // ******************************************************************
    // ALU
    // ******************************************************************
    assign aluDataB = (aluBSel == ALU_B_IMM) ? immByte : regOutB;

    alu alu0 (
        .dataA  (regOutA),
        .dataB  (aluDataB),
        .mode   (aluMode),
        .cin    (carryFlag),
        .result (aluResult),
        .cout   (aluCarry),
        .zout   (aluZero),
        .nout   (aluNeg)
    );

    // Data memory side
    assign dMemAddress = {regOutC, regOutB};
    assign dMemIn      = aluResult;

    // ******************************************************************
    // Status register
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            carryFlag    <= 1'b0;
            zeroFlag     <= 1'b0;
            negativeFlag <= 1'b0;
        end else if (flagEnable) begin      // ALU instructions only
            carryFlag    <= aluCarry;
            zeroFlag     <= aluZero;
            negativeFlag <= aluNeg;
        end
    end

    // ******************************************************************
    // Program counter
    // ******************************************************************
    always_comb begin
        case (pcSel)
            PC_HOLD: nextPc = pc;
            PC_JUMP: nextPc = iMemOut;      // Absolute target word
            default: nextPc = pc + ADDR_WIDTH'(1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pcWriteEn) begin
            pc <= nextPc;
        end
    end

    assign iMemAddress = pc;                // Fetch address is the PC itself

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::INSTR_WIDTH-1:0]  instr,
    input  logic                            carryFlag,
    input  logic                            zeroFlag,
    output logic                            regWriteEn,
    output cpuPkg::regSrcT                  regSrc,
    output cpuPkg::aluBSelT                 aluBSel,
    output cpuPkg::aluModeT                 aluMode,
    output logic                            flagEnable,
    output cpuPkg::pcSelT                   pcSel,
    output logic                            pcWriteEn,
    output logic                            dMemReadEn,
    output logic                            dMemWriteEn,
    output logic                            iMemReadEnable,
    output logic                            halted
);
    import cpuPkg::*;

    typedef enum logic [1:0] {
        EXECUTE     = 2'd0,
        JUMP_TARGET = 2'd1,     // Target word is on the bus
        HALTED      = 2'd2
    } stateT;

    stateT  state;
    stateT  nextState;
    opcodeT opcode;
    logic   branchCond;
    logic   jumpTaken;

    assign opcode = opcodeT'(instr[3:0]);

    // Condition of the jump in the execute cycle
    always_comb begin
        case (opcode)
            OP_JZ:   branchCond = zeroFlag;
            OP_JC:   branchCond = carryFlag;
            default: branchCond = 1'b1;     // JMP always taken
        endcase
    end

    // ******************************************************************
    // State register
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= EXECUTE;
            jumpTaken <= 1'b0;
        end else begin
            state <= nextState;
            if (state == EXECUTE) begin
                jumpTaken <= branchCond;    // Held for the target cycle
            end
        end
    end

    // ******************************************************************
    // Decode
    // ******************************************************************
    always_comb begin
        regWriteEn     = 1'b0;
        regSrc         = REG_SRC_ALU;
        aluBSel        = ALU_B_REG;
        aluMode        = ALU_PASS_A;
        flagEnable     = 1'b0;
        pcSel          = PC_INC;
        pcWriteEn      = 1'b1;
        dMemReadEn     = 1'b0;
        dMemWriteEn    = 1'b0;
        iMemReadEnable = 1'b1;
        halted         = 1'b0;
        nextState      = state;

        case (state)
            EXECUTE: begin
                case (opcode)
                    OP_ADD, OP_ADC, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                        regWriteEn = 1'b1;
                        flagEnable = 1'b1;
                        // Opcodes 0..5 line up with the ALU modes
                        aluMode    = aluModeT'(opcode[2:0]);
                    end
                    OP_LDI: begin
                        regWriteEn = 1'b1;
                        regSrc     = REG_SRC_IMM;
                        aluBSel    = ALU_B_IMM;
                        aluMode    = ALU_PASS_B;
                    end
                    OP_LD: begin
                        regWriteEn = 1'b1;
                        regSrc     = REG_SRC_DMEM;
                        dMemReadEn = 1'b1;
                    end
                    OP_ST: begin
                        dMemWriteEn = 1'b1;         // Register A through the ALU
                    end
                    OP_JMP, OP_JZ, OP_JC: begin
                        nextState = JUMP_TARGET;    // PC steps onto the target word
                    end
                    OP_HALT: begin
                        pcSel     = PC_HOLD;
                        nextState = HALTED;
                    end
                    default: begin
                    end
                endcase
            end
            JUMP_TARGET: begin
                // Load the target, or step over it when not taken
                pcSel     = jumpTaken ? PC_JUMP : PC_INC;
                nextState = EXECUTE;
            end
            HALTED: begin
                pcSel          = PC_HOLD;
                pcWriteEn      = 1'b0;
                iMemReadEnable = 1'b0;
                halted         = 1'b1;      // Until reset
            end
            default: begin
                nextState = EXECUTE;
            end
        endcase
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cpuPkg::REG_SEL_WIDTH-1:0]  selA,
    input  logic [cpuPkg::REG_SEL_WIDTH-1:0]  selB,
    input  logic [cpuPkg::DATA_WIDTH-1:0]     writeData,
    input  logic                              writeEn,
    output logic [cpuPkg::DATA_WIDTH-1:0]     outA,
    output logic [cpuPkg::DATA_WIDTH-1:0]     outB,
    output logic [cpuPkg::DATA_WIDTH-1:0]     outC
);
    import cpuPkg::*;

    logic [DATA_WIDTH-1:0]    regs [NUM_REGS];
    logic [REG_SEL_WIDTH-1:0] selC;

    // ******************************************************************
    // Pair select
    // ******************************************************************
    // High byte of the pair sits one above B, 15 wraps to 0
    assign selC = selB + REG_SEL_WIDTH'(1);

    // ******************************************************************
    // Storage
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[selA] <= writeData;        // A is also the destination
        end
    end

    // ******************************************************************
    // Read ports
    // ******************************************************************
    assign outA = regs[selA];
    assign outB = regs[selB];               // Pair low byte for LD and ST
    assign outC = regs[selC];               // Pair high byte

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::DATA_WIDTH-1:0] dataA,
    input  logic [cpuPkg::DATA_WIDTH-1:0] dataB,
    input  cpuPkg::aluModeT               mode,
    input  logic                          cin,
    output logic [cpuPkg::DATA_WIDTH-1:0] result,
    output logic                          cout,
    output logic                          zout,
    output logic                          nout
);
    import cpuPkg::*;

    // One extra bit to catch the carry
    logic [DATA_WIDTH:0] sum;

    // ******************************************************************
    // Arithmetic and logic
    // ******************************************************************
    always_comb begin
        sum    = '0;
        result = '0;
        cout   = 1'b0;
        case (mode)
            ALU_ADD: begin
                sum    = {1'b0, dataA} + {1'b0, dataB};
                result = sum[DATA_WIDTH-1:0];
                cout   = sum[DATA_WIDTH];
            end
            ALU_ADC: begin
                sum    = {1'b0, dataA} + {1'b0, dataB} + (DATA_WIDTH + 1)'(cin);
                result = sum[DATA_WIDTH-1:0];
                cout   = sum[DATA_WIDTH];
            end
            ALU_SUB: begin
                // Two's complement add, carry set means no borrow
                sum    = {1'b0, dataA} + {1'b0, ~dataB} + (DATA_WIDTH + 1)'(1);
                result = sum[DATA_WIDTH-1:0];
                cout   = sum[DATA_WIDTH];
            end
            ALU_AND:    result = dataA & dataB;
            ALU_OR:     result = dataA | dataB;
            ALU_XOR:    result = dataA ^ dataB;
            ALU_PASS_A: result = dataA;     // Store data
            ALU_PASS_B: result = dataB;     // Immediate load
            default: begin
                result = dataA;
            end
        endcase
    end

    // ******************************************************************
    // Flags from the result
    // ******************************************************************
    assign zout = (result == '0);
    assign nout = result[DATA_WIDTH-1];    // Sign bit

endmodule

// ==== src/cpuPkg.sv ====
package cpuPkg;

    // ******************************************************************
    // Widths
    // ******************************************************************
    localparam int DATA_WIDTH    = 8;
    localparam int ADDR_WIDTH    = 16;
    localparam int INSTR_WIDTH   = 16;
    localparam int NUM_REGS      = 16;
    localparam int REG_SEL_WIDTH = 4;

    localparam logic [ADDR_WIDTH-1:0] RESET_PC = '0;   // First fetch after reset

    // ******************************************************************
    // Encodings
    // ******************************************************************
    // Opcode in instruction bits 3..0, codes 13 to 15 are no operation
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_ADC  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_LDI  = 4'h6,
        OP_LD   = 4'h7,
        OP_ST   = 4'h8,
        OP_JMP  = 4'h9,
        OP_JZ   = 4'hA,
        OP_JC   = 4'hB,
        OP_HALT = 4'hC
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_ADC    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_OR     = 3'd4,
        ALU_XOR    = 3'd5,
        ALU_PASS_A = 3'd6,
        ALU_PASS_B = 3'd7
    } aluModeT;

    typedef enum logic [1:0] {
        REG_SRC_ALU  = 2'b00,   // ALU result
        REG_SRC_IMM  = 2'b01,   // Immediate byte
        REG_SRC_DMEM = 2'b10    // Data memory read
    } regSrcT;

    typedef enum logic {
        ALU_B_REG = 1'b0,
        ALU_B_IMM = 1'b1
    } aluBSelT;

    typedef enum logic [1:0] {
        PC_INC  = 2'b00,
        PC_HOLD = 2'b01,
        PC_JUMP = 2'b10         // Target word on iMemOut
    } pcSelT;

endpackage
